// File: design/snes_mem_config.svh
`ifndef SNES_MEM_CONFIG_SVH
`define SNES_MEM_CONFIG_SVH

// word memory shared by all clients
`define SM_WADDR_W 12           // word address, top bits are the region
`define SM_REGION_W 2
`define SM_PADDR_W 12           // byte address of one SNES port

// region codes, port i lands in region i+1
`define SM_REGION_ROM 2'd0
`define SM_REGION_WRAM 2'd1
`define SM_REGION_BSRAM 2'd2
`define SM_REGION_ARAM 2'd3

`define SM_STORE_LAT 2          // store read latency in cycles

`define SM_NUM_PORTS 3
// loader, bridge, then the ports
`define SM_NUM_REQ (`SM_NUM_PORTS + 2)

`endif

// File: design/snes_mem_pkg.sv
`include "snes_mem_config.svh"

package snes_mem_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // one 16-bit word access to the store
    typedef struct packed {
        logic [`SM_WADDR_W-1:0] word_addr;
        logic [15:0]            wdata;
        logic [1:0]             lanes;      // bit 1 is the high byte
        mem_op_e                op;
    } mem_req_t;

    // byte-wide SNES port
    typedef struct packed {
        logic [`SM_PADDR_W-1:0] addr;
        logic [7:0]             wdata;
        logic                   rd;
        logic                   wr;
    } port_bus_t;

    // 32-bit softcore access, zero strobe means read
    typedef struct packed {
        logic [10:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } rv_req_t;

    typedef enum logic [1:0] {
        rv_idle,
        rv_wait_lo,
        rv_wait_hi
    } rv_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_busy,
        arb_done
    } arb_state_e;

endpackage

// File: design/port_tracker.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module port_tracker #(
    parameter logic [`SM_REGION_W-1:0] REGION = `SM_REGION_WRAM
) (
    input  logic                     mclk,
    input  logic                     resetn,
    input  snes_mem_pkg::port_bus_t  bus,
    input  logic                     ack,
    input  logic [15:0]              rdata,
    output logic                     req,
    output snes_mem_pkg::mem_req_t   req_data,
    output logic                     pending,
    output logic [7:0]               byte_rdata
);
    logic                   rd_r;
    logic                   wr_r;
    logic [`SM_WADDR_W-1:0] word_addr;
    logic [`SM_WADDR_W-1:0] last_addr;
    logic [15:0]            word_q;     // last word read back
    logic                   launch;

    // byte address bits above the region field alias
    assign word_addr = {REGION, bus.addr[`SM_WADDR_W-`SM_REGION_W:1]};

    // edges are only looked at while no access is outstanding
    assign launch = !pending && ((bus.rd && !rd_r) || (bus.wr && !wr_r) ||
                                 (bus.rd && word_addr != last_addr));

    // byte pick follows the live address, so a held read of the other byte works
    assign byte_rdata = bus.addr[0] ? word_q[15:8] : word_q[7:0];

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            rd_r      <= 1'b0;
            wr_r      <= 1'b0;
            last_addr <= '0;
            req       <= 1'b0;
            pending   <= 1'b0;
        end else begin
            if (!pending) begin
                rd_r <= bus.rd;
                wr_r <= bus.wr;
            end
            if (launch) begin
                req                <= ~req;
                pending            <= 1'b1;
                last_addr          <= word_addr;
                req_data.word_addr <= word_addr;
                req_data.wdata     <= {bus.wdata, bus.wdata};   // same byte on both lanes
                req_data.lanes     <= {bus.addr[0], ~bus.addr[0]};
                req_data.op        <= bus.wr ? snes_mem_pkg::op_write : snes_mem_pkg::op_read;
            end else if (pending && req == ack) begin
                pending <= 1'b0;
                if (req_data.op == snes_mem_pkg::op_read)
                    word_q <= rdata;
            end
        end
    end

    // the SNES side never reads and writes one port at once
    a_rd_wr_exclusive: assert property (@(posedge mclk) disable iff (!resetn)
        !(bus.rd && bus.wr));

endmodule

// File: design/rom_loader.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module rom_loader (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    load_active,
    input  logic [7:0]              load_byte,
    input  logic                    load_valid,
    input  logic                    ack,
    output logic                    req,
    output snes_mem_pkg::mem_req_t  req_data,
    output logic                    loaded
);
    // byte counter covers the whole ROM region
    localparam int CNT_W = `SM_WADDR_W - `SM_REGION_W + 1;

    logic             active_r;
    logic [CNT_W-1:0] count;
    logic [7:0]       prev_byte;    // even byte waiting for its pair
    logic             take;

    assign take = load_active && load_valid;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            active_r <= 1'b0;
            count    <= '0;
            req      <= 1'b0;
            loaded   <= 1'b0;
        end else begin
            active_r <= load_active;
            if (take) begin
                count     <= count + CNT_W'(1);
                prev_byte <= load_byte;
                if (count[0]) begin                 // odd byte completes a word
                    req                <= ~req;
                    req_data.word_addr <= {`SM_REGION_ROM, count[CNT_W-1:1]};
                    req_data.wdata     <= {load_byte, prev_byte};
                    req_data.lanes     <= 2'b11;
                    req_data.op        <= snes_mem_pkg::op_write;
                end
            end
            if (load_active && !active_r) begin      // new load starts over
                count  <= '0;
                loaded <= 1'b0;
            end
            if (!load_active && active_r)
                loaded <= 1'b1;
        end
    end

    // byte stream has no back-pressure, previous word must be done by now
    a_no_overrun: assert property (@(posedge mclk) disable iff (!resetn)
        (take && count[0]) |-> (req == ack));

endmodule

// File: design/rv_bridge.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module rv_bridge (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    rv_valid,
    input  snes_mem_pkg::rv_req_t   rv_req,
    input  logic                    ack,
    input  logic [15:0]             rdata,
    output logic                    rv_ready,
    output logic [31:0]             rv_rdata,
    output logic                    req,
    output snes_mem_pkg::mem_req_t  req_data
);
    snes_mem_pkg::rv_state_e state;
    logic [15:0]             lo_word;
    logic                    is_write;
    logic                    done;      // outstanding half came back

    assign is_write = rv_req.wstrb != 4'b0;
    assign done     = req == ack;

    // word access for one half of the 32-bit request
    function automatic snes_mem_pkg::mem_req_t half_req(input snes_mem_pkg::rv_req_t r,
                                                         input logic hi);
        snes_mem_pkg::mem_req_t m;
        m.word_addr = {r.addr, hi};
        m.wdata     = hi ? r.wdata[31:16] : r.wdata[15:0];
        if (r.wstrb == 4'b0) begin
            m.lanes = 2'b11;
            m.op    = snes_mem_pkg::op_read;
        end else begin
            m.lanes = hi ? r.wstrb[3:2] : r.wstrb[1:0];
            m.op    = snes_mem_pkg::op_write;
        end
        return m;
    endfunction

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state    <= snes_mem_pkg::rv_idle;
            req      <= 1'b0;
            rv_ready <= 1'b0;
        end else begin
            rv_ready <= 1'b0;
            case (state)
                snes_mem_pkg::rv_idle: begin
                    // valid is still up during the ready cycle, skip it
                    if (rv_valid && !rv_ready) begin
                        req <= ~req;
                        if (is_write && rv_req.wstrb[1:0] == 2'b00) begin
                            req_data <= half_req(rv_req, 1'b1);    // high half only
                            state    <= snes_mem_pkg::rv_wait_hi;
                        end else begin
                            req_data <= half_req(rv_req, 1'b0);
                            state    <= snes_mem_pkg::rv_wait_lo;
                        end
                    end
                end
                snes_mem_pkg::rv_wait_lo: begin
                    if (done) begin
                        lo_word <= rdata;
                        if (is_write && rv_req.wstrb[3:2] == 2'b00) begin
                            rv_ready <= 1'b1;
                            state    <= snes_mem_pkg::rv_idle;
                        end else begin
                            req      <= ~req;
                            req_data <= half_req(rv_req, 1'b1);
                            state    <= snes_mem_pkg::rv_wait_hi;
                        end
                    end
                end
                snes_mem_pkg::rv_wait_hi: begin
                    if (done) begin
                        rv_rdata <= {rdata, lo_word};
                        rv_ready <= 1'b1;
                        state    <= snes_mem_pkg::rv_idle;
                    end
                end
                default: state <= snes_mem_pkg::rv_idle;
            endcase
        end
    end

    // softcore keeps its request up until it gets ready
    a_valid_held: assert property (@(posedge mclk) disable iff (!resetn)
        (rv_valid && !rv_ready) |=> (rv_valid || rv_ready));

endmodule

// File: design/word_arbiter.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module word_arbiter (
    input  logic                                        mclk,
    input  logic                                        resetn,
    input  logic [`SM_NUM_REQ-1:0]                      reqs,       // 0 is loader, 1 bridge
    input  snes_mem_pkg::mem_req_t [`SM_NUM_REQ-1:0]    req_data,
    input  logic [15:0]                                 st_rdata,
    output logic [`SM_NUM_REQ-1:0]                      acks,
    output logic [15:0]                                 rdata,
    output logic                                        st_en,
    output snes_mem_pkg::mem_req_t                      st_req
);
    localparam int IDX_W = $clog2(`SM_NUM_REQ);
    localparam int CNT_W = $clog2(`SM_STORE_LAT + 1);

    snes_mem_pkg::arb_state_e state;
    logic [`SM_NUM_REQ-1:0]   pend;
    logic [IDX_W-1:0]         pick;
    logic [IDX_W-1:0]         gnt;      // requester being served
    logic                     found;
    logic [CNT_W-1:0]         cnt;

    assign pend = reqs ^ acks;

    // fixed priority, lowest index wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = `SM_NUM_REQ - 1; i >= 0; i--) begin
            if (pend[i]) begin
                pick  = IDX_W'(i);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state <= snes_mem_pkg::arb_idle;
            acks  <= '0;
            st_en <= 1'b0;
            cnt   <= '0;
        end else begin
            st_en <= 1'b0;      // one issue cycle per grant
            case (state)
                snes_mem_pkg::arb_idle: begin
                    if (found) begin
                        gnt    <= pick;
                        st_req <= req_data[pick];
                        st_en  <= 1'b1;
                        cnt    <= '0;
                        state  <= snes_mem_pkg::arb_busy;
                    end
                end
                snes_mem_pkg::arb_busy: begin
                    // store pipeline drains
                    cnt <= cnt + CNT_W'(1);
                    if (cnt == CNT_W'(`SM_STORE_LAT - 1))
                        state <= snes_mem_pkg::arb_done;
                end
                snes_mem_pkg::arb_done: begin
                    // read word is on st_rdata now
                    rdata     <= st_rdata;
                    acks[gnt] <= ~acks[gnt];
                    state     <= snes_mem_pkg::arb_idle;
                end
                default: state <= snes_mem_pkg::arb_idle;
            endcase
        end
    end

    // completion only goes back to a client that asked
    a_ack_pending: assert property (@(posedge mclk) disable iff (!resetn)
        ((acks ^ $past(acks)) & ~$past(reqs ^ acks)) == '0);

endmodule

// File: design/word_store.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module word_store (
    input  logic                    mclk,
    input  logic                    en,
    input  snes_mem_pkg::mem_req_t  req,
    output logic [15:0]             rdata
);
    localparam int DEPTH = 1 << `SM_WADDR_W;

    logic [15:0] mem [DEPTH];
    logic [15:0] pipe [`SM_STORE_LAT];     // read stages

    always_ff @(posedge mclk) begin
        if (en && req.op == snes_mem_pkg::op_write) begin
            if (req.lanes[0])
                mem[req.word_addr][7:0] <= req.wdata[7:0];
            if (req.lanes[1])
                mem[req.word_addr][15:8] <= req.wdata[15:8];
        end
    end

    // read returns the word as it was before a same-cycle write
    always_ff @(posedge mclk) begin
        pipe[0] <= mem[req.word_addr];
        for (int i = 1; i < `SM_STORE_LAT; i++)
            pipe[i] <= pipe[i-1];
    end

    assign rdata = pipe[`SM_STORE_LAT-1];

endmodule

// File: design/snes_mem_top.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module snes_mem_top (
    input  logic                                        mclk,
    input  logic                                        resetn,
    // SNES byte ports, 0 WRAM, 1 BSRAM, 2 ARAM
    input  snes_mem_pkg::port_bus_t [`SM_NUM_PORTS-1:0] port_bus,
    output logic [`SM_NUM_PORTS-1:0][7:0]               port_rdata,
    output logic [`SM_NUM_PORTS-1:0]                    port_pending,
    // ROM loader stream
    input  logic                                        load_active,
    input  logic [7:0]                                  load_byte,
    input  logic                                        load_valid,
    output logic                                        loaded,
    // softcore bus
    input  logic                                        rv_valid,
    input  snes_mem_pkg::rv_req_t                       rv_req,
    output logic                                        rv_ready,
    output logic [31:0]                                 rv_rdata
);
    localparam logic [`SM_NUM_PORTS-1:0][`SM_REGION_W-1:0] PORT_REGION =
        {`SM_REGION_ARAM, `SM_REGION_BSRAM, `SM_REGION_WRAM};

    logic [`SM_NUM_REQ-1:0]                   reqs;
    logic [`SM_NUM_REQ-1:0]                   acks;
    snes_mem_pkg::mem_req_t [`SM_NUM_REQ-1:0] req_data;
    logic [15:0]                              rdata;      // shared completion data
    logic                                     st_en;
    snes_mem_pkg::mem_req_t                   st_req;
    logic [15:0]                              st_rdata;

    rom_loader rom_loader_inst (
        .mclk(mclk), .resetn(resetn),
        .load_active(load_active), .load_byte(load_byte), .load_valid(load_valid),
        .ack(acks[0]), .req(reqs[0]), .req_data(req_data[0]), .loaded(loaded)
    );

    rv_bridge rv_bridge_inst (
        .mclk(mclk), .resetn(resetn),
        .rv_valid(rv_valid), .rv_req(rv_req), .ack(acks[1]), .rdata(rdata),
        .rv_ready(rv_ready), .rv_rdata(rv_rdata), .req(reqs[1]), .req_data(req_data[1])
    );

    for (genvar i = 0; i < `SM_NUM_PORTS; i++) begin : g_port
        port_tracker #(.REGION(PORT_REGION[i])) port_tracker_inst (
            .mclk(mclk), .resetn(resetn),
            .bus(port_bus[i]), .ack(acks[i+2]), .rdata(rdata),
            .req(reqs[i+2]), .req_data(req_data[i+2]),
            .pending(port_pending[i]), .byte_rdata(port_rdata[i])
        );
    end

    word_arbiter word_arbiter_inst (
        .mclk(mclk), .resetn(resetn),
        .reqs(reqs), .req_data(req_data), .st_rdata(st_rdata),
        .acks(acks), .rdata(rdata), .st_en(st_en), .st_req(st_req)
    );

    word_store word_store_inst (
        .mclk(mclk), .en(st_en), .req(st_req), .rdata(st_rdata)
    );

endmodule

// File: verif/snes_mem_ref.svh
`ifndef SNES_MEM_REF_SVH
`define SNES_MEM_REF_SVH

// shadow of the word store, known marks bytes written so far
logic [15:0] shadow [1 << `SM_WADDR_W];
bit   [1:0]  known  [1 << `SM_WADDR_W];

// port p lives in region p+1, byte address bit 11 aliases onto bit 10
function automatic logic [`SM_WADDR_W-1:0] port_word(input int p,
                                                     input logic [`SM_PADDR_W-1:0] addr);
    logic [1:0] region;
    region = 2'(p + 1);
    return {region, addr[10:1]};
endfunction

function automatic logic [15:0] lane_merge(input logic [15:0] old_word,
                                           input logic [15:0] new_word,
                                           input logic [1:0]  lanes);
    logic [15:0] w;
    w = old_word;
    if (lanes[0])
        w[7:0] = new_word[7:0];
    if (lanes[1])
        w[15:8] = new_word[15:8];
    return w;
endfunction

function automatic void shadow_write(input logic [`SM_WADDR_W-1:0] word_addr,
                                     input logic [15:0] data, input logic [1:0] lanes);
    shadow[word_addr] = lane_merge(shadow[word_addr], data, lanes);
    known[word_addr]  = known[word_addr] | lanes;
endfunction

// loader puts the even byte low
function automatic logic [15:0] pair_bytes(input logic [7:0] even_byte,
                                           input logic [7:0] odd_byte);
    return {odd_byte, even_byte};
endfunction

function automatic logic [31:0] join_halves(input logic [15:0] lo, input logic [15:0] hi);
    return {hi, lo};
endfunction

function automatic logic [31:0] rv_expect(input logic [10:0] addr);
    return join_halves(shadow[{addr, 1'b0}], shadow[{addr, 1'b1}]);
endfunction

function automatic logic [31:0] rv_known(input logic [10:0] addr);
    logic [3:0]  k;
    logic [31:0] m;
    k = {known[{addr, 1'b1}], known[{addr, 1'b0}]};
    for (int i = 0; i < 4; i++)
        m[8*i +: 8] = {8{k[i]}};
    return m;
endfunction

function automatic logic [7:0] port_expect(input int p, input logic [`SM_PADDR_W-1:0] addr);
    logic [15:0] w;
    w = shadow[port_word(p, addr)];
    return addr[0] ? w[15:8] : w[7:0];
endfunction

function automatic logic [7:0] port_known(input int p, input logic [`SM_PADDR_W-1:0] addr);
    return known[port_word(p, addr)][addr[0]] ? 8'hff : 8'h00;
endfunction

`endif

// File: verif/snes_mem_tb.sv
`timescale 1ns/1ps
`include "snes_mem_config.svh"

module snes_mem_tb;
    // about 400 accesses at no more than 40 cycles each
    localparam int MAX_CYCLES = 20000;

    logic                                        mclk;
    logic                                        resetn;
    snes_mem_pkg::port_bus_t [`SM_NUM_PORTS-1:0] port_bus;
    logic [`SM_NUM_PORTS-1:0][7:0]               port_rdata;
    logic [`SM_NUM_PORTS-1:0]                    port_pending;
    logic                                        load_active;
    logic [7:0]                                  load_byte;
    logic                                        load_valid;
    logic                                        loaded;
    logic                                        rv_valid;
    snes_mem_pkg::rv_req_t                       rv_req;
    logic                                        rv_ready;
    logic [31:0]                                 rv_rdata;

    typedef struct {
        string       name;
        logic [31:0] exp;
        logic [31:0] act;
        logic [31:0] mask;      // bytes with a known value
        bit          plain;     // status check, name holds the message
        bit          ok;
    } check_t;

    check_t     checks [$];
    int         errors = 0;
    int         num_checks = 0;
    int         cycles = 0;
    integer     seed;
    logic [7:0] rom_bytes [64];

    `include "snes_mem_ref.svh"

    snes_mem_top snes_mem_top_inst (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    function automatic void push_check(input string name, input logic [31:0] exp,
                                       input logic [31:0] act, input logic [31:0] mask);
        check_t c;
        c.name  = name;
        c.exp   = exp;
        c.act   = act;
        c.mask  = mask;
        c.plain = 1'b0;
        c.ok    = 1'b1;
        checks.push_back(c);
    endfunction

    function automatic void push_status(input bit ok, input string msg);
        check_t c;
        c.name  = msg;
        c.plain = 1'b1;
        c.ok    = ok;
        checks.push_back(c);
    endfunction

    function automatic void print_counts();
        $display("Summary: %0d checks, %0d errors", num_checks, errors);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // fixed corner strobes first, then random nonzero ones
    function automatic logic [3:0] strobe_for(input int k);
        logic [31:0] r;
        case (k)
            0: return 4'b0011;
            1: return 4'b1100;
            2: return 4'b0001;
            3: return 4'b1000;
            default: begin
                r = $random(seed);
                return (r[3:0] == 4'b0) ? 4'b0101 : r[3:0];
            end
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge mclk);
        #2;
    endtask

    task automatic port_write(input int p, input logic [11:0] addr, input logic [7:0] data);
        port_bus[p].addr  = addr;
        port_bus[p].wdata = data;
        port_bus[p].wr    = 1'b1;
        shadow_write(port_word(p, addr), {data, data}, addr[0] ? 2'b10 : 2'b01);
        next_cycle();
        push_status(port_pending[p] == 1'b1, $sformatf("port %0d write never went pending", p));
        port_bus[p].wr = 1'b0;
        while (port_pending[p])
            next_cycle();
        next_cycle();       // edge detector sees the port idle
    endtask

    task automatic port_read(input int p, input logic [11:0] addr, input string name);
        port_bus[p].addr = addr;
        port_bus[p].rd   = 1'b1;
        next_cycle();
        push_status(port_pending[p] == 1'b1, $sformatf("port %0d read never went pending", p));
        while (port_pending[p])
            next_cycle();
        push_check(name, 32'(port_expect(p, addr)), 32'(port_rdata[p]),
                   32'(port_known(p, addr)));
        port_bus[p].rd = 1'b0;
        next_cycle();
    endtask

    task automatic rv_access(input logic [10:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
        rv_req.addr  = addr;
        rv_req.wdata = wdata;
        rv_req.wstrb = wstrb;
        rv_valid     = 1'b1;
        shadow_write({addr, 1'b0}, wdata[15:0], wstrb[1:0]);     // zero strobe is a read
        shadow_write({addr, 1'b1}, wdata[31:16], wstrb[3:2]);
        next_cycle();
        while (!rv_ready)
            next_cycle();
        rdata    = rv_rdata;
        rv_valid = 1'b0;
        next_cycle();
    endtask

    task automatic rv_read_check(input logic [10:0] addr, input string name);
        logic [31:0] r;
        rv_access(addr, 32'h0, 4'b0000, r);
        push_check(name, rv_expect(addr), r, rv_known(addr));
    endtask

    task automatic load_rom();
        load_active = 1'b1;
        next_cycle();                           // start edge clears the counter
        for (int i = 0; i < 64; i++) begin
            rom_bytes[i] = rand_byte();
            load_byte    = rom_bytes[i];
            load_valid   = 1'b1;
            if (i % 2 == 1)
                shadow_write({`SM_REGION_ROM, 10'(i / 2)},
                             pair_bytes(rom_bytes[i-1], rom_bytes[i]), 2'b11);
            next_cycle();
            load_valid = 1'b0;
            repeat (7) next_cycle();
        end
        load_active = 1'b0;
        repeat (2) next_cycle();                // loaded follows the falling edge
    endtask

    always @(posedge mclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // results are compared away from the active edge
    always @(negedge mclk) begin
        check_t c;
        while (checks.size() > 0) begin
            c = checks.pop_front();
            num_checks++;
            if (c.plain) begin
                assert (c.ok) else begin
                    $display("%s", c.name);
                    errors++;
                end
            end else begin
                assert ((c.act & c.mask) === (c.exp & c.mask)) else begin
                    $display("Mismatch %s: expected %h, actual %h", c.name,
                             c.exp & c.mask, c.act & c.mask);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] unused_rd;
        logic [11:0] a;
        logic [11:0] wa;
        logic [10:0] ra;
        seed        = 32'h75c2_0e58;
        resetn      = 1'b0;
        port_bus    = '0;
        load_active = 1'b0;
        load_byte   = 8'h00;
        load_valid  = 1'b0;
        rv_valid    = 1'b0;
        rv_req      = '0;
        repeat (4) @(posedge mclk);
        #2 resetn = 1'b1;
        next_cycle();
        push_check("reset_state", 32'h0, 32'({port_pending, rv_ready, loaded}), 32'h1f);

        load_rom();
        push_check("loaded_flag", 32'h1, 32'(loaded), 32'h1);
        for (int w = 0; w < 16; w++) begin
            rv_access(11'(w), 32'h0, 4'b0000, r);
            push_check($sformatf("rom_word_%0d", w),
                       join_halves(pair_bytes(rom_bytes[4*w], rom_bytes[4*w+1]),
                                   pair_bytes(rom_bytes[4*w+2], rom_bytes[4*w+3])),
                       r, 32'hffff_ffff);
        end

        // neighbour gets a value first, then each byte write must keep the other
        for (int p = 0; p < `SM_NUM_PORTS; p++) begin
            for (int k = 0; k < 4; k++) begin
                r = $random(seed);
                a = r[11:0];
                port_write(p, a ^ 12'h1, rand_byte());
                port_write(p, a, r[19:12]);
                port_read(p, a, $sformatf("lane_p%0d_%0d_first", p, k));
                port_read(p, a ^ 12'h1, $sformatf("lane_p%0d_%0d_other", p, k));
                port_write(p, a ^ 12'h1, r[27:20]);
                port_read(p, a, $sformatf("lane_p%0d_%0d_kept", p, k));
                port_read(p, a ^ 12'h1, $sformatf("lane_p%0d_%0d_second", p, k));
            end
        end

        // one byte address on all ports lands in three regions
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            a = r[11:0] ^ r[31:20];
            for (int p = 0; p < `SM_NUM_PORTS; p++)
                port_write(p, a, r[8*p +: 8]);
            for (int p = 0; p < `SM_NUM_PORTS; p++) begin
                wa = port_word(p, a);
                rv_read_check(wa[11:1], $sformatf("region_p%0d_%0d", p, k));
            end
        end

        for (int k = 0; k < 8; k++) begin
            ra = 11'h100 + 11'(k);
            wd = $random(seed);
            rv_access(ra, wd, 4'b1111, unused_rd);
            wd = $random(seed);
            rv_access(ra, wd, strobe_for(k), unused_rd);
            rv_read_check(ra, $sformatf("partial_%0d", k));
        end

        // all ports and the bridge start in the same cycle
        for (int k = 0; k < 4; k++) begin
            r  = $random(seed);
            wd = $random(seed);
            a  = r[11:0];
            ra = 11'h180 + 11'(k);
            fork
                port_write(0, a, r[19:12]);
                port_write(1, a ^ 12'h1, r[27:20]);
                port_write(2, a, ~r[19:12]);
                rv_access(ra, wd, 4'b1111, unused_rd);
            join
            fork
                port_read(0, a, $sformatf("busy_p0_%0d", k));
                port_read(1, a ^ 12'h1, $sformatf("busy_p1_%0d", k));
                port_read(2, a, $sformatf("busy_p2_%0d", k));
                rv_read_check(ra, $sformatf("busy_rv_%0d", k));
            join
            push_check($sformatf("busy_pending_%0d", k), 32'h0, 32'(port_pending), 32'h7);
        end

        repeat (2) next_cycle();
        print_counts();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
+incdir+verif
design/snes_mem_pkg.sv
design/port_tracker.sv
design/rom_loader.sv
design/rv_bridge.sv
design/word_arbiter.sv
design/word_store.sv
design/snes_mem_top.sv
verif/snes_mem_tb.sv

// File: run.sh
#!/bin/bash
# build and run the testbench with Verilator, fail if the log reports failure
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module snes_mem_tb -f project.f

./obj_dir/Vsnes_mem_tb | tee sim.log

if grep -qF -- '*** TEST FAILED ***' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
